// ==== src/memtest_pkg.sv ====
// shared widths, register map, command codes and engine states for the memory test subsystem
`default_nettype none

package memtest_pkg;

  localparam int DATA_W  = 32;  // wishbone and avalon data word
  localparam int BURST_W = 8;   // burst count, 0 means 1
  localparam int ERR_W   = 16;  // mismatch counter, saturating

  // STATUS register bit positions, err_count sits in the top half
  localparam int STAT_READY     = 0;
  localparam int STAT_TEST_DONE = 1;
  localparam int STAT_TEST_PASS = 2;
  localparam int STAT_WR_DONE   = 3;
  localparam int STAT_RD_DONE   = 4;
  localparam int STAT_DROPPED   = 5;
  localparam int STAT_ERR_LSB   = DATA_W - ERR_W;

  // word addresses on wb_adr[3:0]
  typedef enum logic [3:0] {
    CSR_CTRL     = 4'd0,
    CSR_ADDR     = 4'd1,
    CSR_WDATA    = 4'd2,
    CSR_BURST    = 4'd3,
    CSR_PATTERN  = 4'd4,
    CSR_RDATA    = 4'd5,
    CSR_STATUS   = 4'd6,
    CSR_CHECKSUM = 4'd7,
    CSR_ERRINFO  = 4'd8
  } csr_addr_e;

  // command code in CTRL[2:0]
  typedef enum logic [2:0] {
    CMD_NONE      = 3'd0,
    CMD_ADDR_TEST = 3'd1,  // write addr^pattern everywhere, then read back
    CMD_VERIFY    = 3'd2,  // read back only
    CMD_SW_WRITE  = 3'd3,
    CMD_SW_READ   = 3'd4,
    CMD_CLEAR     = 3'd5   // drop done flags and cmd_dropped
  } cmd_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_TEST_WR, ST_TEST_RD, ST_WR_BURST, ST_RD_REQ, ST_RD_RSP
  } eng_state_e;

endpackage

`default_nettype wire

// ==== src/avmm_if.sv ====
// avalon-mm bus between the test engine (master) and the memory model (slave)
`timescale 1ns/1ps
`default_nettype none

interface avmm_if #(
  parameter int ADDR_W = 6  // word address bits
) ();
  import memtest_pkg::*;

  logic [ADDR_W-1:0]  address;        // held for a whole burst
  logic               write;
  logic               read;
  logic [DATA_W-1:0]  writedata;
  logic [BURST_W-1:0] burstcount;
  logic               waitrequest;    // beat accepted when low
  logic [DATA_W-1:0]  readdata;
  logic               readdatavalid;  // one per returned beat, in order

  modport master (
    output address, write, read, writedata, burstcount,
    input  waitrequest, readdata, readdatavalid
  );

  modport slave (
    input  address, write, read, writedata, burstcount,
    output waitrequest, readdata, readdatavalid
  );

endinterface

`default_nettype wire

// ==== src/memtest_csr.sv ====
// wishbone classic register block: holds test setup, issues engine commands, reports status
`timescale 1ns/1ps
`default_nettype none

module memtest_csr (
  input  wire logic                       pClk,
  input  wire logic                       reset,
  input  wire logic                       wb_cyc,
  input  wire logic                       wb_stb,
  input  wire logic                       wb_we,
  input  wire logic [3:0]                 wb_adr,
  input  wire logic [memtest_pkg::DATA_W-1:0] wb_dat_w,
  output logic [memtest_pkg::DATA_W-1:0]  wb_dat_r,
  output logic                            wb_ack,
  output logic                            cmd_valid,    // one cycle, together with ack
  output memtest_pkg::cmd_e               cmd,
  output logic [memtest_pkg::DATA_W-1:0]  base_addr,
  output logic [memtest_pkg::DATA_W-1:0]  wdata,
  output logic [memtest_pkg::BURST_W-1:0] burst,
  output logic [memtest_pkg::DATA_W-1:0]  pattern,
  input  wire logic                       busy,
  input  wire logic [memtest_pkg::DATA_W-1:0] rdata,
  input  wire logic [memtest_pkg::DATA_W-1:0] checksum,
  input  wire logic [memtest_pkg::ERR_W-1:0]  err_count,
  input  wire logic [memtest_pkg::DATA_W-1:0] first_err_addr,
  input  wire logic                       test_done,
  input  wire logic                       wr_done,
  input  wire logic                       rd_done
);
  import memtest_pkg::*;

  logic              accept;       // new access seen this cycle
  csr_addr_e         reg_sel;
  cmd_e              new_cmd;
  logic              cmd_dropped;  // sticky, cleared by CMD_CLEAR
  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] rd_mux;

  assign accept  = wb_cyc & wb_stb & ~wb_ack;  // ack low in between, one ack per access
  assign reg_sel = csr_addr_e'(wb_adr);
  assign new_cmd = cmd_e'(wb_dat_w[2:0]);

  always_comb begin
    status_word                 = '0;
    status_word[STAT_READY]     = ~busy;
    status_word[STAT_TEST_DONE] = test_done;
    status_word[STAT_TEST_PASS] = test_done & (err_count == '0);
    status_word[STAT_WR_DONE]   = wr_done;
    status_word[STAT_RD_DONE]   = rd_done;
    status_word[STAT_DROPPED]   = cmd_dropped;
    status_word[DATA_W-1:STAT_ERR_LSB] = err_count;
  end

  always_comb begin
    case (reg_sel)
      CSR_CTRL:     rd_mux = DATA_W'(cmd);  // last command issued
      CSR_ADDR:     rd_mux = base_addr;
      CSR_WDATA:    rd_mux = wdata;
      CSR_BURST:    rd_mux = DATA_W'(burst);
      CSR_PATTERN:  rd_mux = pattern;
      CSR_RDATA:    rd_mux = rdata;
      CSR_STATUS:   rd_mux = status_word;
      CSR_CHECKSUM: rd_mux = checksum;
      CSR_ERRINFO:  rd_mux = first_err_addr;
      default:      rd_mux = '0;            // unmapped words
    endcase
  end

  // ************************************************************
  // register writes and command pulse
  // ************************************************************
  always_ff @(posedge pClk) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      wb_dat_r    <= '0;
      cmd_valid   <= 1'b0;
      cmd         <= CMD_NONE;
      cmd_dropped <= 1'b0;
      base_addr   <= '0;
      wdata       <= '0;
      burst       <= '0;
      pattern     <= '0;
    end else begin
      wb_ack    <= accept;
      cmd_valid <= 1'b0;
      if (accept & ~wb_we) wb_dat_r <= rd_mux;  // valid with ack
      if (accept & wb_we) begin
        case (reg_sel)
          CSR_CTRL: begin
            if (busy) begin
              cmd_dropped <= 1'b1;  // engine still running, command lost
            end else begin
              cmd       <= new_cmd;
              cmd_valid <= 1'b1;
              if (new_cmd == CMD_CLEAR) cmd_dropped <= 1'b0;
            end
          end
          CSR_ADDR:    base_addr <= wb_dat_w;
          CSR_WDATA:   wdata     <= wb_dat_w;
          CSR_BURST:   burst     <= wb_dat_w[BURST_W-1:0];
          CSR_PATTERN: pattern   <= wb_dat_w;
          default: ;  // read-only words ignore writes
        endcase
      end
    end
  end

  cmd_to_idle: assert property (@(posedge pClk) disable iff (reset) cmd_valid |-> !busy);

endmodule

`default_nettype wire

// ==== src/memtest_engine.sv ====
// avalon-mm master FSM: runs the address test, the verify pass and software bursts
`timescale 1ns/1ps
`default_nettype none

module memtest_engine #(
  parameter int ADDR_W = 6
) (
  input  wire logic                        pClk,
  input  wire logic                        reset,
  input  wire logic                        cmd_valid,
  input  wire memtest_pkg::cmd_e           cmd,
  input  wire logic [memtest_pkg::DATA_W-1:0]  base_addr,  // low ADDR_W bits used
  input  wire logic [memtest_pkg::DATA_W-1:0]  wdata,
  input  wire logic [memtest_pkg::BURST_W-1:0] burst,
  input  wire logic [memtest_pkg::DATA_W-1:0]  pattern,
  output logic                             busy,
  output logic [memtest_pkg::DATA_W-1:0]   rdata,       // last read beat
  output logic [memtest_pkg::DATA_W-1:0]   checksum,    // xor of read beats
  output logic [memtest_pkg::ERR_W-1:0]    err_count,
  output logic [memtest_pkg::DATA_W-1:0]   first_err_addr,
  output logic                             test_done,
  output logic                             wr_done,
  output logic                             rd_done,
  avmm_if.master                           mem
);
  import memtest_pkg::*;

  localparam logic [ADDR_W-1:0] LAST_ADDR = '1;  // top of memory

  eng_state_e         state;
  logic [BURST_W-1:0] beat;      // beat index inside a software burst
  logic [BURST_W-1:0] bc_eff;    // burst count, 0 taken as 1
  logic               wr_acc;
  logic               rd_acc;
  logic               mismatch;

  function automatic logic [DATA_W-1:0] exp_word(input logic [ADDR_W-1:0] a);
    return DATA_W'(a) ^ pattern;  // test data for address a
  endfunction

  assign bc_eff   = (burst == '0) ? BURST_W'(1) : burst;
  assign wr_acc   = mem.write & ~mem.waitrequest;
  assign rd_acc   = mem.read & ~mem.waitrequest;
  assign mismatch = mem.readdata != exp_word(mem.address);  // address held until data back

  always_ff @(posedge pClk) begin
    if (reset) begin
      state          <= ST_IDLE;
      busy           <= 1'b0;
      mem.write      <= 1'b0;
      mem.read       <= 1'b0;
      mem.address    <= '0;
      mem.writedata  <= '0;
      mem.burstcount <= BURST_W'(1);
      beat           <= '0;
      rdata          <= '0;
      checksum       <= '0;
      err_count      <= '0;
      first_err_addr <= '0;
      test_done      <= 1'b0;
      wr_done        <= 1'b0;
      rd_done        <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (cmd_valid) begin
          case (cmd)
            CMD_ADDR_TEST, CMD_VERIFY: begin
              state          <= (cmd == CMD_VERIFY) ? ST_TEST_RD : ST_TEST_WR;
              busy           <= 1'b1;
              mem.write      <= (cmd == CMD_ADDR_TEST);
              mem.read       <= (cmd == CMD_VERIFY);  // verify skips the write sweep
              mem.address    <= '0;
              mem.writedata  <= exp_word('0);
              mem.burstcount <= BURST_W'(1);            // single beats only
              test_done      <= 1'b0;
              err_count      <= '0;
              first_err_addr <= '0;
            end
            CMD_SW_WRITE: begin
              state          <= ST_WR_BURST;
              busy           <= 1'b1;
              mem.write      <= 1'b1;
              mem.address    <= base_addr[ADDR_W-1:0];
              mem.writedata  <= wdata;
              mem.burstcount <= bc_eff;
              beat           <= '0;
              wr_done        <= 1'b0;
            end
            CMD_SW_READ: begin
              state          <= ST_RD_REQ;
              busy           <= 1'b1;
              mem.read       <= 1'b1;
              mem.address    <= base_addr[ADDR_W-1:0];
              mem.burstcount <= bc_eff;
              beat           <= '0;
              checksum       <= '0;
              rd_done        <= 1'b0;
            end
            CMD_CLEAR: begin
              test_done <= 1'b0;
              wr_done   <= 1'b0;
              rd_done   <= 1'b0;
            end
            default: ;
          endcase
        end

        ST_TEST_WR: if (wr_acc) begin
          if (mem.address == LAST_ADDR) begin  // sweep done, turn around to reads
            state       <= ST_TEST_RD;
            mem.write   <= 1'b0;
            mem.read    <= 1'b1;
            mem.address <= '0;
          end else begin
            mem.address   <= mem.address + 1'b1;
            mem.writedata <= exp_word(mem.address + 1'b1);
          end
        end

        ST_TEST_RD: begin
          if (rd_acc) mem.read <= 1'b0;  // one read outstanding
          if (mem.readdatavalid) begin
            if (mismatch) begin
              if (err_count != '1) err_count <= err_count + 1'b1;  // saturate
              if (err_count == '0) first_err_addr <= DATA_W'(mem.address);
            end
            if (mem.address == LAST_ADDR) begin
              state     <= ST_IDLE;
              busy      <= 1'b0;
              test_done <= 1'b1;
            end else begin
              mem.address <= mem.address + 1'b1;
              mem.read    <= 1'b1;
            end
          end
        end

        // ************************************************************
        // software bursts
        // ************************************************************
        ST_WR_BURST: if (wr_acc) begin
          if (beat == mem.burstcount - 1'b1) begin
            state     <= ST_IDLE;
            mem.write <= 1'b0;
            busy      <= 1'b0;
            wr_done   <= 1'b1;
          end else begin
            beat          <= beat + 1'b1;
            mem.writedata <= mem.writedata + 1'b1;  // beat i carries wdata + i
          end
        end

        ST_RD_REQ: if (rd_acc) begin  // whole burst requested in one beat
          state    <= ST_RD_RSP;
          mem.read <= 1'b0;
        end

        ST_RD_RSP: if (mem.readdatavalid) begin
          rdata    <= mem.readdata;
          checksum <= checksum ^ mem.readdata;
          beat     <= beat + 1'b1;
          if (beat == mem.burstcount - 1'b1) begin
            state   <= ST_IDLE;
            busy    <= 1'b0;
            rd_done <= 1'b1;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  rw_exclusive: assert property (@(posedge pClk) disable iff (reset) !(mem.read && mem.write));

  addr_held: assert property (@(posedge pClk) disable iff (reset)
    (mem.read || mem.write) && mem.waitrequest |=> $stable(mem.address));

endmodule

`default_nettype wire

// ==== src/avmm_ram.sv ====
// avalon-mm memory model with wait states and fixed read latency, for standalone simulation
`timescale 1ns/1ps
`default_nettype none

module avmm_ram #(
  parameter int ADDR_W      = 6,
  parameter int WAIT_STATES = 1,  // waitrequest cycles per beat
  parameter int RD_LATENCY  = 2   // accept or issue to readdatavalid, at least 1
) (
  input  wire logic pClk,
  input  wire logic reset,
  avmm_if.slave     mem
);
  import memtest_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;
  localparam int WS_W  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [DATA_W-1:0]  ram_q [DEPTH];
  logic [WS_W-1:0]    ws_cnt;          // wait cycles spent on current beat
  logic               cmd_acc;
  logic               wr_acc;
  logic               rd_acc;
  logic [BURST_W-1:0] bc_eff;
  logic [BURST_W-1:0] wr_beat;         // offset inside a write burst
  logic [BURST_W-1:0] rd_left;         // read beats still to issue
  logic [ADDR_W-1:0]  wr_addr;
  logic [ADDR_W-1:0]  rd_addr;
  logic [ADDR_W-1:0]  rd_sel;
  logic               rd_issue;
  logic [RD_LATENCY-1:0] vld_pipe;
  logic [DATA_W-1:0]  dat_pipe [RD_LATENCY];

  assign mem.waitrequest   = (mem.read | mem.write) & (ws_cnt != WS_W'(WAIT_STATES));
  assign cmd_acc           = (mem.read | mem.write) & ~mem.waitrequest;
  assign wr_acc            = mem.write & ~mem.waitrequest;
  assign rd_acc            = mem.read & ~mem.waitrequest;
  assign bc_eff            = (mem.burstcount == '0) ? BURST_W'(1) : mem.burstcount;
  assign wr_addr           = mem.address + ADDR_W'(wr_beat);  // wraps at DEPTH
  assign rd_issue          = rd_acc | (rd_left != '0);
  assign rd_sel            = rd_acc ? mem.address : rd_addr;   // first beat goes out at accept
  assign mem.readdatavalid = vld_pipe[RD_LATENCY-1];
  assign mem.readdata      = dat_pipe[RD_LATENCY-1];

  always_ff @(posedge pClk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) ram_q[i] <= '0;
      ws_cnt   <= '0;
      wr_beat  <= '0;
      rd_left  <= '0;
      rd_addr  <= '0;
      vld_pipe <= '0;
    end else begin
      ws_cnt <= mem.waitrequest ? ws_cnt + 1'b1 : '0;  // restarts for every beat
      if (wr_acc) begin
        ram_q[wr_addr] <= mem.writedata;
        wr_beat <= (wr_beat == bc_eff - 1'b1) ? '0 : wr_beat + 1'b1;
      end
      if (rd_acc) begin
        rd_left <= bc_eff - 1'b1;
        rd_addr <= mem.address + 1'b1;
      end else if (rd_left != '0) begin
        rd_left <= rd_left - 1'b1;
        rd_addr <= rd_addr + 1'b1;
      end
      vld_pipe[0] <= rd_issue;
      for (int i = 1; i < RD_LATENCY; i++) vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  always_ff @(posedge pClk) begin  // read data pipeline
    dat_pipe[0] <= ram_q[rd_sel];
    for (int i = 1; i < RD_LATENCY; i++) dat_pipe[i] <= dat_pipe[i-1];
  end

  no_cmd_while_pending: assert property (@(posedge pClk) disable iff (reset)
    cmd_acc |-> (rd_left == '0) && (vld_pipe == '0));

endmodule

`default_nettype wire

// ==== src/memtest_top.sv ====
// memory test subsystem top: wishbone host port, register block, test engine and memory
`timescale 1ns/1ps
`default_nettype none

module memtest_top #(
  parameter int ADDR_W      = 6,  // memory holds 2**ADDR_W words
  parameter int WAIT_STATES = 1,
  parameter int RD_LATENCY  = 2
) (
  input  wire logic                           pClk,
  input  wire logic                           reset,
  input  wire logic                           wb_cyc,
  input  wire logic                           wb_stb,
  input  wire logic                           wb_we,
  input  wire logic [3:0]                     wb_adr,
  input  wire logic [memtest_pkg::DATA_W-1:0] wb_dat_w,
  output logic [memtest_pkg::DATA_W-1:0]      wb_dat_r,
  output logic                                wb_ack
);
  import memtest_pkg::*;

  // csr to engine
  logic               cmd_valid;
  cmd_e               cmd;
  logic [DATA_W-1:0]  base_addr;
  logic [DATA_W-1:0]  wdata;
  logic [BURST_W-1:0] burst;
  logic [DATA_W-1:0]  pattern;
  // engine to csr
  logic               busy;
  logic [DATA_W-1:0]  rdata;
  logic [DATA_W-1:0]  checksum;
  logic [ERR_W-1:0]   err_count;
  logic [DATA_W-1:0]  first_err_addr;
  logic               test_done;
  logic               wr_done;
  logic               rd_done;

  avmm_if #(.ADDR_W(ADDR_W)) mem_bus ();  // engine to memory

  memtest_csr memtest_csr_i (
    .pClk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .cmd_valid, .cmd, .base_addr, .wdata, .burst, .pattern,
    .busy, .rdata, .checksum, .err_count, .first_err_addr, .test_done, .wr_done, .rd_done
  );

  memtest_engine #(.ADDR_W(ADDR_W)) memtest_engine_i (
    .pClk, .reset, .cmd_valid, .cmd, .base_addr, .wdata, .burst, .pattern,
    .busy, .rdata, .checksum, .err_count, .first_err_addr, .test_done, .wr_done, .rd_done,
    .mem (mem_bus.master)
  );

  avmm_ram #(.ADDR_W(ADDR_W), .WAIT_STATES(WAIT_STATES), .RD_LATENCY(RD_LATENCY)) avmm_ram_i (
    .pClk, .reset, .mem (mem_bus.slave)
  );

endmodule

`default_nettype wire

// ==== dv/memtest_checker.sv ====
// testbench monitor: checks acked wishbone reads against posted expected values and keeps counts
`timescale 1ns/1ps
`default_nettype none

module memtest_checker (
  input  wire logic                           pClk,
  input  wire logic                           wb_cyc,
  input  wire logic                           wb_we,
  input  wire logic                           wb_ack,
  input  wire logic [memtest_pkg::DATA_W-1:0] wb_dat_r,
  input  wire logic                           exp_valid,   // driver has posted a value
  input  wire logic [memtest_pkg::DATA_W-1:0] exp_data,
  input  wire logic [memtest_pkg::DATA_W-1:0] exp_mask,    // only set bits are compared
  input  wire logic [31:0]                    test_id,
  input  wire logic                           run_done,
  output int                                  fail_total,
  output int                                  check_total
);
  import memtest_pkg::*;

  int          test_checks;  // counts for the test in progress
  int          test_fails;
  logic [31:0] cur_id;
  logic        closed;       // closing line already printed

  initial begin
    fail_total  = 0;
    check_total = 0;
    test_checks = 0;
    test_fails  = 0;
    cur_id      = '0;
    closed      = 1'b0;
  end

  // ************************************************************
  // sample on the falling edge, away from driver and DUT updates
  // ************************************************************
  always @(negedge pClk) begin
    if (run_done && !closed) begin
      $display("test %0d finished: %0d checks, %0d errors", cur_id, test_checks, test_fails);
      $display("totals: %0d checks, %0d errors", check_total, fail_total);
      closed = 1'b1;
    end else if (test_id != cur_id) begin
      if (cur_id != '0) begin  // previous test just ended
        $display("test %0d finished: %0d checks, %0d errors", cur_id, test_checks, test_fails);
      end
      cur_id      = test_id;
      test_checks = 0;
      test_fails  = 0;
    end
    if (wb_cyc && wb_ack && !wb_we && exp_valid) begin
      check_total++;
      test_checks++;
      if ((wb_dat_r & exp_mask) != (exp_data & exp_mask)) begin
        fail_total++;
        test_fails++;
        $display("[FAIL] %0t ns: test %0d read 0x%08h, expected 0x%08h under mask 0x%08h",
                 $time, test_id, wb_dat_r, exp_data, exp_mask);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/memtest_tb.sv ====
// testbench top: clock, reset, wishbone host tasks and a table of test steps run in a loop
`timescale 1ns/1ps
`default_nettype none

module memtest_tb;
  import memtest_pkg::*;

  localparam int ADDR_W      = 6;
  localparam int WAIT_STATES = 1;
  localparam int RD_LATENCY  = 2;
  localparam int DEPTH       = 2 ** ADDR_W;

  typedef enum {OP_WR, OP_RUN, OP_RD} op_e;  // register write, command + poll, checked read

  typedef struct {
    op_e         op;
    logic [3:0]  adr;
    logic [31:0] data;  // write data, or command code for OP_RUN
    logic [31:0] exp;
    logic [31:0] mask;
    logic [31:0] id;
  } step_t;

  logic              pClk;
  logic              reset;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [3:0]        wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic              exp_valid;
  logic [31:0]       exp_data;
  logic [31:0]       exp_mask;
  logic [31:0]       test_id;
  logic              run_done;
  int                fail_total;
  int                check_total;
  step_t             steps[$];
  logic [31:0]       rng;

  memtest_top #(.ADDR_W(ADDR_W), .WAIT_STATES(WAIT_STATES), .RD_LATENCY(RD_LATENCY)) memtest_top_i (
    .pClk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  memtest_checker memtest_checker_i (
    .pClk, .wb_cyc, .wb_we, .wb_ack, .wb_dat_r, .exp_valid, .exp_data, .exp_mask,
    .test_id, .run_done, .fail_total, .check_total
  );

  initial begin
    pClk = 1'b0;
    forever #10 pClk = ~pClk;  // 20 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // xor of the beats d, d+1 .. d+n-1
  function automatic logic [31:0] burst_xor(input logic [31:0] d, input int n);
    logic [31:0] x;
    x = '0;
    for (int i = 0; i < n; i++) x = x ^ (d + 32'(i));
    return x;
  endfunction

  function automatic logic [31:0] status_bits(input logic tdone, input logic tpass,
      input logic wdone, input logic rdone, input logic dropped, input logic [ERR_W-1:0] errs);
    logic [31:0] s;
    s = '0;
    s[STAT_READY]     = 1'b1;  // status only checked once idle
    s[STAT_TEST_DONE] = tdone;
    s[STAT_TEST_PASS] = tpass;
    s[STAT_WR_DONE]   = wdone;
    s[STAT_RD_DONE]   = rdone;
    s[STAT_DROPPED]   = dropped;
    s[DATA_W-1:STAT_ERR_LSB] = errs;
    return s;
  endfunction

  task automatic write_step(input logic [3:0] adr, input logic [31:0] data, input int id);
    step_t s;
    s = '{OP_WR, adr, data, 32'h0, 32'h0, 32'(id)};
    steps.push_back(s);
  endtask

  task automatic read_step(input logic [3:0] adr, input logic [31:0] exp, input logic [31:0] mask,
      input int id);
    step_t s;
    s = '{OP_RD, adr, 32'h0, exp, mask, 32'(id)};
    steps.push_back(s);
  endtask

  task automatic command_step(input cmd_e c, input int id);
    step_t s;
    s = '{OP_RUN, CSR_CTRL, 32'(c), 32'h0, 32'h0, 32'(id)};
    steps.push_back(s);
  endtask

  // ************************************************************
  // step table, expected values from the register map rules
  // ************************************************************
  task automatic build_table();
    logic [31:0] d;
    logic [31:0] a;
    logic [31:0] pat;
    int          n;
    // reset state and plain register readback
    read_step(CSR_STATUS, status_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0), '1, 1);
    read_step(CSR_RDATA, 32'h0, '1, 1);
    read_step(CSR_CHECKSUM, 32'h0, '1, 1);
    read_step(CSR_ERRINFO, 32'h0, '1, 1);
    write_step(CSR_ADDR, 32'h1234_5678, 1);
    write_step(CSR_WDATA, 32'hdead_beef, 1);
    write_step(CSR_BURST, 32'h0000_00a5, 1);  // 8 bit field
    write_step(CSR_PATTERN, 32'h5a5a_0ff0, 1);
    read_step(CSR_ADDR, 32'h1234_5678, '1, 1);
    read_step(CSR_WDATA, 32'hdead_beef, '1, 1);
    read_step(CSR_BURST, 32'h0000_00a5, '1, 1);
    read_step(CSR_PATTERN, 32'h5a5a_0ff0, '1, 1);
    // address test then verify, same pattern
    pat = 32'hc3a5_0f96;
    write_step(CSR_PATTERN, pat, 2);
    command_step(CMD_ADDR_TEST, 2);
    read_step(CSR_STATUS, status_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 16'd0), '1, 2);
    command_step(CMD_VERIFY, 2);
    read_step(CSR_STATUS, status_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 16'd0), '1, 2);
    read_step(CSR_ERRINFO, 32'h0, '1, 2);
    for (int k = 0; k < 4; k++) begin  // random software bursts
      rng = xorshift(rng);
      d   = rng;
      rng = xorshift(rng);
      n   = int'(rng[2:0]) + 1;        // 1 to 8 beats
      rng = xorshift(rng);
      a   = 32'(rng[ADDR_W-1:0]);
      write_step(CSR_ADDR, a, 3);
      write_step(CSR_WDATA, d, 3);
      write_step(CSR_BURST, 32'(n), 3);
      command_step(CMD_SW_WRITE, 3);
      command_step(CMD_SW_READ, 3);
      read_step(CSR_RDATA, d + 32'(n - 1), '1, 3);
      read_step(CSR_CHECKSUM, burst_xor(d, n), '1, 3);
      read_step(CSR_STATUS, status_bits(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 16'd0), 32'h0000_0019, 3);
    end
    // one corrupted word found by verify
    a = 32'h0000_0015;
    command_step(CMD_ADDR_TEST, 4);
    write_step(CSR_ADDR, a, 4);
    write_step(CSR_WDATA, ~(a ^ pat), 4);
    write_step(CSR_BURST, 32'h1, 4);
    command_step(CMD_SW_WRITE, 4);
    command_step(CMD_VERIFY, 4);
    read_step(CSR_STATUS, status_bits(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 16'd1), 32'hffff_0006, 4);
    read_step(CSR_ERRINFO, a, '1, 4);
    // command while busy is dropped, clear resets the flags
    write_step(CSR_CTRL, 32'(CMD_ADDR_TEST), 5);
    command_step(CMD_VERIFY, 5);   // lands while busy
    read_step(CSR_STATUS, status_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 16'd0), 32'h0000_0027, 5);
    command_step(CMD_CLEAR, 5);
    read_step(CSR_STATUS, status_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0), '1, 5);
    // burst across the top of memory
    rng = xorshift(rng);
    d   = rng;
    write_step(CSR_ADDR, 32'(DEPTH - 2), 6);
    write_step(CSR_WDATA, d, 6);
    write_step(CSR_BURST, 32'h4, 6);
    command_step(CMD_SW_WRITE, 6);
    write_step(CSR_ADDR, 32'h0, 6);
    write_step(CSR_BURST, 32'h1, 6);
    command_step(CMD_SW_READ, 6);
    read_step(CSR_RDATA, d + 32'h2, '1, 6);   // third beat wrapped to 0
    write_step(CSR_ADDR, 32'(DEPTH - 2), 6);
    write_step(CSR_BURST, 32'h4, 6);
    command_step(CMD_SW_READ, 6);
    read_step(CSR_CHECKSUM, burst_xor(d, 4), '1, 6);
  endtask

  // one classic access, entered and left 2 ns after a rising edge
  task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
      output logic [31:0] rd);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      @(posedge pClk);
      #1;
    end while (!wb_ack);
    rd = wb_dat_r;
    @(posedge pClk);  // ack taken on this edge, cycle ends after it
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic run_command(input cmd_e c);
    logic [31:0] rd;
    wb_cycle(1'b1, CSR_CTRL, 32'(c), rd);
    do begin
      wb_cycle(1'b0, CSR_STATUS, 32'h0, rd);  // poll until engine idle
    end while (!rd[STAT_READY]);
  endtask

  task automatic apply_step(input step_t s);
    logic [31:0] rd;
    test_id = s.id;
    case (s.op)
      OP_WR:  wb_cycle(1'b1, s.adr, s.data, rd);
      OP_RUN: run_command(cmd_e'(s.data[2:0]));
      default: begin
        exp_data  = s.exp;
        exp_mask  = s.mask;
        exp_valid = 1'b1;  // checker compares on the ack
        wb_cycle(1'b0, s.adr, 32'h0, rd);
        exp_valid = 1'b0;
      end
    endcase
  endtask

  initial begin
    reset     = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    exp_valid = 1'b0;
    exp_data  = '0;
    exp_mask  = '0;
    test_id   = '0;
    run_done  = 1'b0;
    rng       = 32'h1ee8;
    build_table();
    repeat (10) @(posedge pClk);
    #2;
    reset = 1'b0;
    foreach (steps[i]) apply_step(steps[i]);
    run_done = 1'b1;
    repeat (2) @(posedge pClk);  // let the checker print its totals
    if (fail_total == 0 && check_total > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // ************************************************************
  // watchdog, sized for a full address test on every step
  // ************************************************************
  initial begin
    int limit;
    int cycle_count;
    #1;
    limit       = steps.size() * (DEPTH * 2 * (WAIT_STATES + RD_LATENCY + 2) + 50);
    cycle_count = 0;
    while (cycle_count < limit) begin
      @(posedge pClk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/memtest_pkg.sv
src/avmm_if.sv
src/memtest_csr.sv
src/memtest_engine.sv
src/avmm_ram.sv
src/memtest_top.sv
dv/memtest_checker.sv
dv/memtest_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the memory test bench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module memtest_tb -f vlog.f -o memtest_sim
out=$(./obj_dir/memtest_sim)
echo "$out"
if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
